// File: source/branch_checkpoint_queue.sv
// FIFO of map and free-head snapshots per branch; held ready bits track the CDB
`timescale 1ns/10ps
`default_nettype none

module branch_checkpoint_queue
  import rename_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        push_i,       // Branch accepted
  input  wire checkpoint_t push_data_i,
  input  wire logic        pop_i,        // Oldest branch predicted right
  input  wire logic        flush_i,      // Mispredict drops everything
  input  wire cdb_t        cdb_i,
  output      checkpoint_t oldest_o,
  output      logic        full_o
);

  checkpoint_t ckpt_q [BR_DEPTH];
  br_ptr_t     rd_ptr_q;  // Oldest entry
  br_ptr_t     wr_ptr_q;  // Next free slot
  br_cnt_t     count_q;

  assign oldest_o = ckpt_q[rd_ptr_q];
  assign full_o   = (count_q == br_cnt_t'(BR_DEPTH));

  // Snapshot storage follows the CDB on every edge
  always_ff @(posedge clk) begin
    for (int e = 0; e < BR_DEPTH; e++) begin
      for (int r = 0; r < NUM_AREG; r++) begin
        if (cdb_match(cdb_i, ckpt_q[e].map[r].preg)) begin
          ckpt_q[e].map[r].rdy <= 1'b1;  // Keep snapshot ready bits current
        end
      end
    end
    // New snapshot already holds this cycle's CDB
    if (push_i) begin
      ckpt_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= wr_ptr_q;  // Empty
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + br_cnt_t'(push_i) - br_cnt_t'(pop_i);
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push_i |-> !full_o)
    else $error("branch_checkpoint_queue: push while full");

  // Resolve must refer to an outstanding branch
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    (pop_i || flush_i) |-> (count_q != '0))
    else $error("branch_checkpoint_queue: resolve with no branch held");

endmodule

`default_nettype wire

// File: source/free_list.sv
// Circular queue of free physical tags; head allocates, retire writes at tail, head restores on mispredict
`timescale 1ns/10ps
`default_nettype none

module free_list
  import rename_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    alloc_en_i,      // Pop head
  input  wire logic    retire_i,        // Push retire_preg_i at tail
  input  wire preg_t   retire_preg_i,
  input  wire logic    restore_i,
  input  wire fl_ptr_t restore_head_i,  // Head saved with the checkpoint
  output      preg_t   free_preg_o,
  output      logic    free_empty_o,
  output      fl_ptr_t free_head_o      // Head after this edge
);

  preg_t   fifo_q [FREE_DEPTH];
  fl_ptr_t head_q;
  fl_ptr_t tail_q;
  fl_ptr_t head_next;
  fl_ptr_t tail_next;
  fl_ptr_t restore_span;  // Entries between restored head and tail
  fl_cnt_t count_q;
  fl_cnt_t count_next;

  always_comb begin
    tail_next    = tail_q + fl_ptr_t'(retire_i);
    restore_span = tail_next - restore_head_i;
    if (restore_i) begin
      head_next = restore_head_i;  // Tail stays, retired tags remain free
      if (restore_span != '0) begin
        count_next = fl_cnt_t'(restore_span);
      end else if (count_q != '0 || retire_i) begin
        count_next = fl_cnt_t'(FREE_DEPTH);  // Wrapped all the way round
      end else begin
        count_next = '0;
      end
    end else begin
      head_next  = head_q + fl_ptr_t'(alloc_en_i);
      count_next = count_q + fl_cnt_t'(retire_i) - fl_cnt_t'(alloc_en_i);
    end
  end

  assign free_preg_o  = fifo_q[head_q];
  assign free_empty_o = (count_q == '0);
  assign free_head_o  = head_next;  // Matches map image after the same edge

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;                     // Full queue, tail wraps onto head
      count_q <= fl_cnt_t'(FREE_DEPTH);
    end else begin
      head_q  <= head_next;
      tail_q  <= tail_next;
      count_q <= count_next;
    end
  end

  // Initial contents are tags above the identity map, in order
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(NUM_AREG + i);
      end
    end else if (retire_i) begin
      fifo_q[tail_q] <= retire_preg_i;
    end
  end

  a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
    alloc_en_i |-> !free_empty_o)
    else $error("free_list: allocation while empty");

  a_no_retire_full: assert property (@(posedge clk) disable iff (rst)
    retire_i |-> (count_q != fl_cnt_t'(FREE_DEPTH)))
    else $error("free_list: retire while full");

endmodule

`default_nettype wire

// File: source/map_table.sv
// Architectural to physical map with ready bits; source lookup, CDB bypass and checkpoint restore
`timescale 1ns/10ps
`default_nettype none

module map_table
  import rename_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire rename_req_t req_i,            // From decode
  input  wire logic        alloc_en_i,       // Accepted dispatch that writes a dest
  input  wire preg_t       new_preg_i,       // Head of free list
  input  wire cdb_t        cdb_i,
  input  wire logic        restore_i,        // Mispredict, reload from checkpoint
  input  wire map_image_t  restore_image_i,
  output      rename_rsp_t rsp_o,
  output      map_image_t  next_image_o      // Snapshot source for a branch
);

  map_image_t map_q;       // Current image, read by lookups
  map_image_t next_image;  // Image after this edge
  map_entry_t opa_ent;
  map_entry_t opb_ent;
  map_entry_t dest_ent;

  // Lookups always use the current image, never the next one
  assign opa_ent  = map_q[req_i.opa_areg];
  assign opb_ent  = map_q[req_i.opb_areg];
  assign dest_ent = map_q[req_i.dest_areg];

  always_comb begin
    rsp_o.opa_preg      = opa_ent.preg;
    rsp_o.opa_rdy       = opa_ent.rdy | cdb_match(cdb_i, opa_ent.preg);  // Same-cycle bypass
    rsp_o.opb_preg      = opb_ent.preg;
    rsp_o.opb_rdy       = opb_ent.rdy | cdb_match(cdb_i, opb_ent.preg);
    rsp_o.dest_old_preg = dest_ent.preg;
    // ZERO_AREG and stalled requests report the current mapping
    if (alloc_en_i) begin
      rsp_o.dest_preg = new_preg_i;
    end else begin
      rsp_o.dest_preg = dest_ent.preg;
    end
  end

  // Build next image: pick base, set ready from CDB, then allocate
  always_comb begin
    if (restore_i) begin
      next_image = restore_image_i;  // Checkpoint already carries older broadcasts
    end else begin
      next_image = map_q;
    end
    for (int i = 0; i < NUM_AREG; i++) begin
      if (cdb_match(cdb_i, next_image[i].preg)) begin
        next_image[i].rdy = 1'b1;
      end
    end
    // New tag starts not ready; allocation overrides a CDB hit on the old tag
    if (alloc_en_i && !restore_i) begin
      next_image[req_i.dest_areg].rdy  = 1'b0;
      next_image[req_i.dest_areg].preg = new_preg_i;
    end
    next_image[ZERO_AREG].rdy = 1'b1;  // Zero register is always ready
  end

  assign next_image_o = next_image;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREG; i++) begin
        map_q[i].rdy  <= 1'b1;        // Identity map, all values committed
        map_q[i].preg <= preg_t'(i);
      end
    end else begin
      map_q <= next_image;
    end
  end

  // Controller must never hand out a tag for the zero register
  a_no_zero_alloc: assert property (@(posedge clk) disable iff (rst)
    alloc_en_i |-> (req_i.dest_areg != areg_t'(ZERO_AREG)))
    else $error("map_table: allocation for ZERO_AREG");

  // Restore only happens while no dispatch is accepted
  a_no_alloc_on_restore: assert property (@(posedge clk) disable iff (rst)
    restore_i |-> !alloc_en_i)
    else $error("map_table: allocation during restore");

endmodule

`default_nettype wire

// File: source/rename_ctrl.sv
// Rename FSM; turns dispatch and resolve strobes into allocate, checkpoint, stall and recover
`timescale 1ns/10ps
`default_nettype none

module rename_ctrl
  import rename_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        dispatch_i,
  input  wire rename_req_t req_i,
  input  wire logic        free_empty_i,
  input  wire logic        ckpt_full_i,
  input  wire logic        resolve_i,     // Oldest branch resolved
  input  wire logic        mispredict_i,
  output      logic        alloc_en_o,
  output      logic        ckpt_push_o,
  output      logic        ckpt_pop_o,
  output      logic        recover_o,
  output      logic        stall_o
);

  rename_state_t state_q;
  logic          needs_reg;  // Dest is a real register
  logic          accept;

  assign needs_reg   = (req_i.dest_areg != areg_t'(ZERO_AREG));
  assign recover_o   = resolve_i && mispredict_i;
  assign ckpt_pop_o  = resolve_i && !mispredict_i;

  // Stall covers both mispredict cycles plus resource shortages
  assign stall_o = (state_q == RECOVER) || recover_o ||
                   (needs_reg && free_empty_i) ||
                   (req_i.is_branch && ckpt_full_i);

  assign accept      = dispatch_i && !stall_o;
  assign alloc_en_o  = accept && needs_reg;
  assign ckpt_push_o = accept && req_i.is_branch;  // Pop in same cycle is fine

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= NORMAL;
    end else begin
      case (state_q)
        NORMAL:  state_q <= recover_o ? RECOVER : NORMAL;
        RECOVER: state_q <= NORMAL;  // Single cycle, restore done at entry edge
        default: state_q <= NORMAL;
      endcase
    end
  end

  // Branch unit holds off resolves until the restore settles
  a_no_resolve_in_recover: assert property (@(posedge clk) disable iff (rst)
    (state_q == RECOVER) |-> !resolve_i)
    else $error("rename_ctrl: resolve during RECOVER");

endmodule

`default_nettype wire

// File: source/rename_pkg.sv
// Shared sizes, vector types, structs and FSM encoding for the rename stage; import with rename_pkg::*
`default_nettype none

package rename_pkg;

  localparam int NUM_AREG   = 32;  // Architectural registers
  localparam int NUM_PREG   = 64;  // Physical registers
  localparam int FREE_DEPTH = 32;  // Free-list capacity, tags 32..63 free at reset
  localparam int BR_DEPTH   = 4;   // Branch checkpoints in flight
  localparam int ZERO_AREG  = 31;  // Never renamed, always ready

  typedef logic [$clog2(NUM_AREG)-1:0]   areg_t;
  typedef logic [$clog2(NUM_PREG)-1:0]   preg_t;
  typedef logic [$clog2(FREE_DEPTH)-1:0] fl_ptr_t;
  typedef logic [$clog2(FREE_DEPTH):0]   fl_cnt_t;  // One extra bit to hold a full count
  typedef logic [$clog2(BR_DEPTH):0]     br_cnt_t;
  typedef logic [$clog2(BR_DEPTH)-1:0]   br_ptr_t;  // Checkpoint FIFO slot index

  typedef struct packed {
    logic  rdy;
    preg_t preg;
  } map_entry_t;

  typedef map_entry_t [NUM_AREG-1:0] map_image_t;  // Whole map, indexed by areg

  typedef struct packed {
    map_image_t map;
    fl_ptr_t    free_head;
  } checkpoint_t;

  typedef struct packed {
    areg_t opa_areg;
    areg_t opb_areg;
    areg_t dest_areg;
    logic  is_branch;
  } rename_req_t;

  typedef struct packed {
    preg_t opa_preg;
    logic  opa_rdy;
    preg_t opb_preg;
    logic  opb_rdy;
    preg_t dest_preg;
    preg_t dest_old_preg;  // Goes to the ROB, freed at retire
  } rename_rsp_t;

  typedef struct packed {
    logic  valid;
    preg_t preg;
  } cdb_t;

  typedef enum logic {
    NORMAL  = 1'b0,
    RECOVER = 1'b1   // One cycle after a mispredict
  } rename_state_t;

  // True when a valid broadcast carries this tag
  function automatic logic cdb_match(cdb_t cdb, preg_t tag);
    return cdb.valid && (cdb.preg == tag);
  endfunction

endpackage

`default_nettype wire

// File: source/rename_unit.sv
// Top of the rename stage; wires controller, map table, free list and checkpoint queue together
`timescale 1ns/10ps
`default_nettype none

module rename_unit
  import rename_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        dispatch_i,
  input  wire rename_req_t req_i,
  input  wire cdb_t        cdb_i,
  input  wire logic        retire_i,
  input  wire preg_t       retire_preg_i,
  input  wire logic        resolve_i,
  input  wire logic        mispredict_i,
  output      rename_rsp_t rsp_o,         // Valid in the dispatch cycle
  output      logic        stall_o
);

  logic        alloc_en;
  logic        ckpt_push;
  logic        ckpt_pop;
  logic        recover;
  preg_t       free_preg;
  logic        free_empty;
  fl_ptr_t     free_head;   // Head after this edge
  map_image_t  next_image;
  checkpoint_t push_data;
  checkpoint_t oldest;      // Restore source on mispredict
  logic        ckpt_full;

  // Snapshot holds the branch's own dest mapping and allocation
  assign push_data.map       = next_image;
  assign push_data.free_head = free_head;

  rename_ctrl i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .dispatch_i   (dispatch_i),
    .req_i        (req_i),
    .free_empty_i (free_empty),
    .ckpt_full_i  (ckpt_full),
    .resolve_i    (resolve_i),
    .mispredict_i (mispredict_i),
    .alloc_en_o   (alloc_en),
    .ckpt_push_o  (ckpt_push),
    .ckpt_pop_o   (ckpt_pop),
    .recover_o    (recover),
    .stall_o      (stall_o)
  );

  map_table i_map (
    .clk             (clk),
    .rst             (rst),
    .req_i           (req_i),
    .alloc_en_i      (alloc_en),
    .new_preg_i      (free_preg),
    .cdb_i           (cdb_i),
    .restore_i       (recover),
    .restore_image_i (oldest.map),
    .rsp_o           (rsp_o),
    .next_image_o    (next_image)
  );

  free_list i_free (
    .clk            (clk),
    .rst            (rst),
    .alloc_en_i     (alloc_en),
    .retire_i       (retire_i),
    .retire_preg_i  (retire_preg_i),
    .restore_i      (recover),
    .restore_head_i (oldest.free_head),
    .free_preg_o    (free_preg),
    .free_empty_o   (free_empty),
    .free_head_o    (free_head)
  );

  branch_checkpoint_queue i_ckpt (
    .clk         (clk),
    .rst         (rst),
    .push_i      (ckpt_push),
    .push_data_i (push_data),
    .pop_i       (ckpt_pop),
    .flush_i     (recover),   // Oldest is restored, younger ones are wrong path
    .cdb_i       (cdb_i),
    .oldest_o    (oldest),
    .full_o      (ckpt_full)
  );

endmodule

`default_nettype wire

// File: tests/rename_checker.sv
// Reference model of the rename stage; samples the DUT ports at the falling edge and compares
`timescale 1ns/10ps
`default_nettype none

module rename_checker
  import rename_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        dispatch_i,
  input  wire rename_req_t req_i,
  input  wire cdb_t        cdb_i,
  input  wire logic        retire_i,
  input  wire preg_t       retire_preg_i,
  input  wire logic        resolve_i,
  input  wire logic        mispredict_i,
  input  wire rename_rsp_t rsp_i,         // DUT response
  input  wire logic        stall_i,
  output int               err_cnt_o,
  output int               chk_cnt_o
);

  map_image_t model_map;     // Mapping as of the last edge
  preg_t      free_seq [$];  // Tags in the order they became free
  int         alloc_idx;     // Next free_seq entry to hand out
  map_image_t ck_map [$];    // Checkpoint images with the oldest at the front
  int         ck_idx [$];    // alloc_idx saved with each image
  logic       in_recover;

  // Any entry holding the broadcast tag becomes ready
  function automatic map_image_t mark_ready(map_image_t img, cdb_t c);
    for (int r = 0; r < NUM_AREG; r++) begin
      if (c.valid && (img[r].preg == c.preg)) begin
        img[r].rdy = 1'b1;
      end
    end
    return img;
  endfunction

  task automatic compare_hex(string name, logic [7:0] exp_val, logic [7:0] act_val);
    chk_cnt_o++;
    if (exp_val !== act_val) begin
      err_cnt_o++;
      $display("Error %s expected 0x%h actual 0x%h at %0t ns", name, exp_val, act_val, $time);
    end
  endtask

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  always @(negedge clk) begin : model_step
    logic       recover;
    logic       needs_reg;
    logic       stall_exp;
    logic       accept;
    map_entry_t a_ent;
    map_entry_t b_ent;
    map_entry_t d_ent;
    if (rst !== 1'b0) begin
      for (int r = 0; r < NUM_AREG; r++) begin
        model_map[r].rdy  = 1'b1;  // Identity map with every value committed
        model_map[r].preg = preg_t'(r);
      end
      free_seq.delete();
      for (int i = 0; i < FREE_DEPTH; i++) begin
        free_seq.push_back(preg_t'(NUM_AREG + i));
      end
      alloc_idx  = 0;
      ck_map.delete();
      ck_idx.delete();
      in_recover = 1'b0;
    end else begin
      recover   = resolve_i && mispredict_i;
      needs_reg = (req_i.dest_areg != areg_t'(ZERO_AREG));
      stall_exp = in_recover || recover ||
                  (needs_reg && (free_seq.size() == alloc_idx)) ||
                  (req_i.is_branch && (ck_map.size() == BR_DEPTH));
      accept    = dispatch_i && !stall_exp;
      compare_hex("stall_o", stall_exp, stall_i);
      a_ent = model_map[req_i.opa_areg];
      b_ent = model_map[req_i.opb_areg];
      d_ent = model_map[req_i.dest_areg];
      if (accept) begin
        compare_hex("rsp_o.opa_preg", a_ent.preg, rsp_i.opa_preg);
        compare_hex("rsp_o.opa_rdy", a_ent.rdy | (cdb_i.valid && cdb_i.preg == a_ent.preg),
                    rsp_i.opa_rdy);  // Bypass counts
        compare_hex("rsp_o.opb_preg", b_ent.preg, rsp_i.opb_preg);
        compare_hex("rsp_o.opb_rdy", b_ent.rdy | (cdb_i.valid && cdb_i.preg == b_ent.preg),
                    rsp_i.opb_rdy);
        compare_hex("rsp_o.dest_preg", needs_reg ? free_seq[alloc_idx] : d_ent.preg,
                    rsp_i.dest_preg);
        compare_hex("rsp_o.dest_old_preg", d_ent.preg, rsp_i.dest_old_preg);
      end
      for (int e = 0; e < ck_map.size(); e++) begin
        ck_map[e] = mark_ready(ck_map[e], cdb_i);  // Held snapshots follow the CDB
      end
      if (recover) begin
        model_map = mark_ready(ck_map[0], cdb_i);
        alloc_idx = ck_idx[0];  // Wrong-path tags go back in order
        ck_map.delete();
        ck_idx.delete();
      end else begin
        model_map = mark_ready(model_map, cdb_i);
        if (accept && needs_reg) begin
          model_map[req_i.dest_areg].preg = free_seq[alloc_idx];
          model_map[req_i.dest_areg].rdy  = 1'b0;
          alloc_idx++;
        end
        if (resolve_i) begin
          void'(ck_map.pop_front());
          void'(ck_idx.pop_front());
        end
        if (accept && req_i.is_branch) begin
          ck_map.push_back(model_map);  // Includes the branch's own dest
          ck_idx.push_back(alloc_idx);
        end
      end
      if (retire_i) begin
        free_seq.push_back(retire_preg_i);
      end
      in_recover = recover;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_rename.sv
// Testbench top for the rename stage; LCG stimulus in phased tests, rename_checker compares
`timescale 1ns/10ps
`default_nettype none

module tb_rename
  import rename_pkg::*;
();

  localparam int PERIOD      = 40;
  localparam int TEST_CYCLES = 32 + 60 + 80 + 88 + 240 + 40;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * PERIOD;  // Margin covers reset and idle

  logic        clk;
  logic        rst;
  logic        dispatch;
  rename_req_t req;
  cdb_t        cdb;
  logic        retire;
  preg_t       retire_preg;
  logic        resolve;
  logic        mispredict;
  rename_rsp_t rsp;
  logic        stall;
  int          err_cnt;         // Counted by the checker
  int          chk_cnt;
  int          tb_err;          // Failures seen on the stimulus side
  logic [31:0] seed;
  preg_t       ret_tag [$];     // Old tags waiting to retire
  int          ret_epoch [$];   // Branches dispatched before each
  int          br_disp;
  int          br_res;
  logic        in_recover;      // No resolve in the cycle after a mispredict
  logic        saw_stall;
  areg_t       last_areg;       // Last renamed dest, aimed at by the CDB
  preg_t       last_preg;

  function automatic int rand_below(int n);
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[30:16]) % n;
  endfunction

  task automatic run_cycles(int n, int disp_pct, int br_pct, int res_pct, int cdb_pct,
                            int ret_pct, int zero_pct);
    for (int c = 0; c < n; c++) begin
      #5;
      dispatch      = rand_below(100) < disp_pct;
      req.opa_areg  = rand_below(2) ? last_areg : areg_t'(rand_below(NUM_AREG));
      req.opb_areg  = areg_t'(rand_below(NUM_AREG));
      req.dest_areg = (rand_below(100) < zero_pct) ? areg_t'(ZERO_AREG)
                                                   : areg_t'(rand_below(ZERO_AREG));
      req.is_branch = rand_below(100) < br_pct;
      cdb.valid     = rand_below(100) < cdb_pct;
      cdb.preg      = rand_below(2) ? last_preg : preg_t'(rand_below(NUM_PREG));
      resolve       = (br_disp > br_res) && !in_recover && (rand_below(100) < res_pct);
      mispredict    = rand_below(2) == 1;
      // Only tags older than every unresolved branch may retire
      retire        = (ret_tag.size() > 0) && (ret_epoch[0] <= br_res) &&
                      (rand_below(100) < ret_pct);
      retire_preg   = '0;
      if (retire) begin
        retire_preg = ret_tag.pop_front();
        void'(ret_epoch.pop_front());
      end
      @(negedge clk);
      if (dispatch && !stall) begin
        if (req.dest_areg != areg_t'(ZERO_AREG)) begin
          ret_tag.push_back(rsp.dest_old_preg);
          ret_epoch.push_back(br_disp);
          last_areg = req.dest_areg;
          last_preg = rsp.dest_preg;
        end
        if (req.is_branch) begin
          br_disp++;
        end
      end
      saw_stall  = saw_stall | stall;
      in_recover = resolve && mispredict;
      if (resolve && mispredict) begin
        while ((ret_epoch.size() > 0) && (ret_epoch[$] > br_res)) begin
          void'(ret_tag.pop_back());  // Wrong path, never retires
          void'(ret_epoch.pop_back());
        end
        br_disp = br_res + 1;  // Younger branches squashed
      end
      br_res = br_res + int'(resolve);
      @(posedge clk);
    end
  endtask

  task automatic report_test(int num, string name, int err_before);
    $display("Test %0d %s: %0d errors", num, name, err_cnt + tb_err - err_before);
  endtask

  rename_unit i_dut (
    .clk           (clk),
    .rst           (rst),
    .dispatch_i    (dispatch),
    .req_i         (req),
    .cdb_i         (cdb),
    .retire_i      (retire),
    .retire_preg_i (retire_preg),
    .resolve_i     (resolve),
    .mispredict_i  (mispredict),
    .rsp_o         (rsp),
    .stall_o       (stall)
  );

  rename_checker i_chk (
    .clk           (clk),
    .rst           (rst),
    .dispatch_i    (dispatch),
    .req_i         (req),
    .cdb_i         (cdb),
    .retire_i      (retire),
    .retire_preg_i (retire_preg),
    .resolve_i     (resolve),
    .mispredict_i  (mispredict),
    .rsp_i         (rsp),
    .stall_i       (stall),
    .err_cnt_o     (err_cnt),
    .chk_cnt_o     (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int base;
    seed        = 32'hc2c3;
    rst         = 1'b1;
    dispatch    = 1'b0;
    req         = '0;
    cdb         = '0;
    retire      = 1'b0;
    retire_preg = '0;
    resolve     = 1'b0;
    mispredict  = 1'b0;
    tb_err      = 0;
    br_disp     = 0;
    br_res      = 0;
    in_recover  = 1'b0;
    saw_stall   = 1'b0;
    last_areg   = '0;
    last_preg   = '0;
    repeat (2) @(posedge clk);
    #5 rst = 1'b0;
    @(posedge clk);
    base = err_cnt + tb_err;
    for (int i = 0; i < NUM_AREG; i++) begin
      #5;
      dispatch      = 1'b1;  // Zero dest, lookups only
      req.opa_areg  = areg_t'(i);
      req.opb_areg  = areg_t'(NUM_AREG - 1 - i);
      req.dest_areg = areg_t'(ZERO_AREG);
      req.is_branch = 1'b0;
      @(posedge clk);
    end
    report_test(1, "reset lookups", base);
    base = err_cnt + tb_err;
    run_cycles(60, 75, 0, 0, 0, 40, 10);
    report_test(2, "random renames", base);
    base = err_cnt + tb_err;
    run_cycles(80, 75, 0, 0, 60, 40, 10);
    report_test(3, "CDB ready and bypass", base);
    base = err_cnt + tb_err;
    saw_stall = 1'b0;
    run_cycles(48, 100, 0, 0, 30, 0, 0);  // No retires, list must drain
    if (!saw_stall) begin
      $display("Free list should have drained but stall_o never went high");
      tb_err++;
    end
    run_cycles(40, 75, 0, 0, 30, 100, 0);
    report_test(4, "free list drain", base);
    base = err_cnt + tb_err;
    run_cycles(240, 75, 25, 30, 30, 40, 10);
    report_test(5, "branches and recovery", base);
    base = err_cnt + tb_err;
    run_cycles(40, 75, 0, 50, 30, 40, 50);
    report_test(6, "zero register", base);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt + tb_err);
    if ((err_cnt + tb_err) == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/rename_pkg.sv
source/map_table.sv
source/free_list.sv
source/branch_checkpoint_queue.sv
source/rename_ctrl.sv
source/rename_unit.sv
tests/rename_checker.sv
tests/tb_rename.sv
